//--- src/lsu_pkg.sv
// Load/store issue stage constants
package lsu_pkg;

	// Data and address width
	localparam int XLEN = 64;

	// Integer register file
	localparam int REG_NUM = 32;
	localparam int REG_AW = 5;

	// Load buffer size and slot index width
	localparam int LU_DEPTH = 4;
	localparam int LU_IW = 2;

	// Store queue depth
	localparam int SU_DEPTH = 4;

	// Fence predecessor and successor set width
	localparam int FENCE_SET_W = 4;

	// Set bits for the load class, input and read
	localparam logic [FENCE_SET_W-1:0] FENCE_LOAD_MASK = 4'b1010;
	// Set bits for the store class, output and write
	localparam logic [FENCE_SET_W-1:0] FENCE_STORE_MASK = 4'b0101;

	// Load dispatch word
	// lb lh lw ld lbu lhu lwu, imm, rd, rs1
	localparam int LU_INFO_W = 7 + XLEN + REG_AW + REG_AW;

	// Load execute word
	// byte half word double, rd, address, unsigned
	localparam int LU_EXEC_W = 4 + REG_AW + XLEN + 1;

	// Store dispatch word
	// sb sh sw sd, imm, rs1, rs2
	localparam int SU_INFO_W = 4 + XLEN + REG_AW + REG_AW;

	// Store execute word
	// width flags, address, data
	localparam int SU_EXEC_W = 4 + XLEN + XLEN;

	// Fence dispatch word
	// fence.i, fence, imm with pred in 7:4 and succ in 3:0
	localparam int FENCE_INFO_W = 2 + XLEN;

	// Fence execute word
	// fence.i, pred, succ
	localparam int FENCE_EXEC_W = 1 + FENCE_SET_W + FENCE_SET_W;

endpackage

//--- src/issue_fifo.sv
// In-order issue queue
module issue_fifo #(
	parameter int DW = 8,
	parameter int DP = 4
) (
	input  logic          CLK,
	input  logic          rst,
	input  logic          push,
	input  logic [DW-1:0] info_push,
	input  logic          pop,
	output logic [DW-1:0] info_pop,
	output logic          full,
	output logic          empty
);

	// Pointer needs at least one bit even for a single entry
	localparam int AW = (DP > 1) ? $clog2(DP) : 1;
	localparam int CW = $clog2(DP + 1);

	// Entry storage
	logic [DW-1:0] mem [DP];

	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;

	logic do_push;
	logic do_pop;

	assign full = (count == CW'(DP));
	assign empty = (count == '0);

	// Pop only from a filled queue
	assign do_pop = pop & ~empty;
	// A full queue still takes a push when the head leaves
	assign do_push = push & (~full | do_pop);

	// Head word
	assign info_pop = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= info_push;
		end
	end

	// Pointers wrap at DP
	always_ff @(posedge CLK) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DP - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DP - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together keep the count
			if (do_push & ~do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop & ~do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- src/lu_slot.sv
// Load buffer entry
module lu_slot (
	input  logic                                    CLK,
	input  logic                                    rst,
	input  logic                                    load,
	input  logic                                    clear,
	input  logic [lsu_pkg::LU_INFO_W-1:0]           info,
	input  logic [lsu_pkg::REG_NUM-1:0]             reg_ready,
	input  logic [lsu_pkg::REG_NUM*lsu_pkg::XLEN-1:0] reg_data,
	output logic                                    occupied,
	output logic                                    ready,
	output logic [lsu_pkg::LU_EXEC_W-1:0]           exec_info
);

	import lsu_pkg::*;

	// Held load word
	logic [LU_INFO_W-1:0] info_q;

	// Decoded fields
	logic op_lb;
	logic op_lh;
	logic op_lw;
	logic op_ld;
	logic op_lbu;
	logic op_lhu;
	logic op_lwu;
	logic [XLEN-1:0] imm;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] rs1;

	// Merged width flags
	logic fun_lb;
	logic fun_lh;
	logic fun_lw;
	logic fun_ld;
	logic is_unsigned;

	logic [XLEN-1:0] addr;

	// Payload only changes on a load strobe
	always_ff @(posedge CLK) begin
		if (load) begin
			info_q <= info;
		end
	end

	// New load wins over a clear in the same cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			occupied <= 1'b0;
		end else if (load) begin
			occupied <= 1'b1;
		end else if (clear) begin
			occupied <= 1'b0;
		end
	end

	assign {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu, imm, rd, rs1} = info_q;

	// Signed and unsigned share a width flag
	assign fun_lb = op_lb | op_lbu;
	assign fun_lh = op_lh | op_lhu;
	assign fun_lw = op_lw | op_lwu;
	assign fun_ld = op_ld;
	assign is_unsigned = op_lbu | op_lhu | op_lwu;

	// Base plus offset
	assign addr = reg_data[rs1*XLEN +: XLEN] + imm;

	// Eligible once the base register is written back
	assign ready = occupied & reg_ready[rs1];

	assign exec_info = {fun_lb, fun_lh, fun_lw, fun_ld, rd, addr, is_unsigned};

endmodule

//--- src/lu_alloc.sv
// Load slot allocator
module lu_alloc (
	input  logic                         issue_valid,
	input  logic [lsu_pkg::LU_DEPTH-1:0] occupied,
	input  logic [lsu_pkg::LU_DEPTH-1:0] pick_clear,
	input  logic                         block,
	output logic                         issue_ready,
	output logic [lsu_pkg::LU_DEPTH-1:0] load
);

	import lsu_pkg::*;

	// Empty now or leaving this cycle
	logic [LU_DEPTH-1:0] free;
	// One-hot lowest free slot
	logic [LU_DEPTH-1:0] first_free;
	logic fire;

	assign free = ~occupied | pick_clear;

	// Isolate the lowest set bit
	assign first_free = free & (~free + 1'b1);

	// Independent of issue_valid
	assign issue_ready = (|free) & ~block;

	// Dispatch transfer
	assign fire = issue_valid & issue_ready;

	// Strobe the chosen slot only on a transfer
	assign load = first_free & {LU_DEPTH{fire}};

endmodule

//--- src/lu_pick.sv
// Ready load picker
module lu_pick (
	input  logic [lsu_pkg::LU_DEPTH-1:0]                    slot_ready,
	input  logic [lsu_pkg::LU_DEPTH*lsu_pkg::LU_EXEC_W-1:0] slot_info,
	input  logic                                            execute_ready,
	output logic                                            execute_valid,
	output logic [lsu_pkg::LU_EXEC_W-1:0]                   execute_info,
	output logic [lsu_pkg::LU_DEPTH-1:0]                    clear
);

	import lsu_pkg::*;

	// Index of the lowest ready slot
	logic [LU_IW-1:0] sel;
	logic fire;

	// Scan from the top so the lowest hit is left last
	always_comb begin
		sel = '0;
		for (int i = LU_DEPTH - 1; i >= 0; i--) begin
			if (slot_ready[i]) begin
				sel = LU_IW'(i);
			end
		end
	end

	// Any ready slot offers a load
	assign execute_valid = |slot_ready;

	// Chosen slot word
	assign execute_info = slot_info[sel*LU_EXEC_W +: LU_EXEC_W];

	// Execute transfer
	assign fire = execute_valid & execute_ready;

	// Release the chosen slot on transfer
	always_comb begin
		clear = '0;
		for (int i = 0; i < LU_DEPTH; i++) begin
			clear[i] = fire & (sel == LU_IW'(i));
		end
	end

endmodule

//--- src/fence_ctrl.sv
// Fence ordering control
module fence_ctrl (
	input  logic [lsu_pkg::FENCE_INFO_W-1:0] fence_info,
	input  logic                             held,
	input  logic                             loads_pending,
	input  logic                             stores_pending,
	output logic                             lu_block,
	output logic                             su_block,
	output logic                             execute_valid,
	output logic [lsu_pkg::FENCE_EXEC_W-1:0] execute_info
);

	import lsu_pkg::*;

	logic is_fence_i;
	logic is_fence;
	logic [FENCE_SET_W-1:0] pred;
	logic [FENCE_SET_W-1:0] succ;

	// Classes the fence orders
	logic wait_loads;
	logic wait_stores;
	logic hold_loads;
	logic hold_stores;

	// Flags on top, sets in the low immediate bits
	assign is_fence_i = fence_info[FENCE_INFO_W-1];
	assign is_fence = fence_info[FENCE_INFO_W-2];
	assign pred = fence_info[2*FENCE_SET_W-1:FENCE_SET_W];
	assign succ = fence_info[FENCE_SET_W-1:0];

	// Predecessor classes that must drain first
	assign wait_loads = is_fence_i | (is_fence & |(pred & FENCE_LOAD_MASK));
	assign wait_stores = is_fence_i | (is_fence & |(pred & FENCE_STORE_MASK));

	// Successor classes kept out while held
	assign hold_loads = is_fence_i | (is_fence & |(succ & FENCE_LOAD_MASK));
	assign hold_stores = is_fence_i | (is_fence & |(succ & FENCE_STORE_MASK));

	assign lu_block = held & hold_loads;
	assign su_block = held & hold_stores;

	// Issue once every ordered older class is empty
	assign execute_valid = held
		& ~(wait_loads & loads_pending)
		& ~(wait_stores & stores_pending);

	assign execute_info = {is_fence_i, pred, succ};

endmodule

//--- src/lsu_issue.sv
// Load/store issue stage
module lsu_issue (
	input  logic                                      CLK,
	input  logic                                      rst,

	// Load path
	input  logic                                      lu_issue_valid,
	output logic                                      lu_issue_ready,
	input  logic [lsu_pkg::LU_INFO_W-1:0]             lu_issue_info,
	output logic                                      lu_execute_valid,
	input  logic                                      lu_execute_ready,
	output logic [lsu_pkg::LU_EXEC_W-1:0]             lu_execute_info,

	// Store path
	input  logic                                      su_issue_valid,
	output logic                                      su_issue_ready,
	input  logic [lsu_pkg::SU_INFO_W-1:0]             su_issue_info,
	output logic                                      su_execute_valid,
	input  logic                                      su_execute_ready,
	output logic [lsu_pkg::SU_EXEC_W-1:0]             su_execute_info,

	// Fence path
	input  logic                                      fence_issue_valid,
	output logic                                      fence_issue_ready,
	input  logic [lsu_pkg::FENCE_INFO_W-1:0]          fence_issue_info,
	output logic                                      fence_execute_valid,
	input  logic                                      fence_execute_ready,
	output logic [lsu_pkg::FENCE_EXEC_W-1:0]          fence_execute_info,

	// Register file
	input  logic [lsu_pkg::REG_NUM-1:0]               reg_ready,
	input  logic [lsu_pkg::REG_NUM*lsu_pkg::XLEN-1:0] reg_data
);

	import lsu_pkg::*;

	// Load buffer
	logic [LU_DEPTH-1:0] lu_load;
	logic [LU_DEPTH-1:0] lu_clear;
	logic [LU_DEPTH-1:0] lu_occupied;
	logic [LU_DEPTH-1:0] lu_slot_ready;
	logic [LU_DEPTH*LU_EXEC_W-1:0] lu_slot_info;
	logic lu_block;

	lu_alloc i_lu_alloc (
		.issue_valid (lu_issue_valid),
		.occupied    (lu_occupied),
		.pick_clear  (lu_clear),
		.block       (lu_block),
		.issue_ready (lu_issue_ready),
		.load        (lu_load)
	);

	// Identical slots, any order out
	for (genvar i = 0; i < LU_DEPTH; i++) begin : g_slot
		lu_slot i_lu_slot (
			.CLK       (CLK),
			.rst       (rst),
			.load      (lu_load[i]),
			.clear     (lu_clear[i]),
			.info      (lu_issue_info),
			.reg_ready (reg_ready),
			.reg_data  (reg_data),
			.occupied  (lu_occupied[i]),
			.ready     (lu_slot_ready[i]),
			.exec_info (lu_slot_info[i*LU_EXEC_W +: LU_EXEC_W])
		);
	end

	lu_pick i_lu_pick (
		.slot_ready    (lu_slot_ready),
		.slot_info     (lu_slot_info),
		.execute_ready (lu_execute_ready),
		.execute_valid (lu_execute_valid),
		.execute_info  (lu_execute_info),
		.clear         (lu_clear)
	);

	// Store queue, head only
	logic su_push;
	logic su_pop;
	logic su_full;
	logic su_empty;
	logic su_block;
	logic [SU_INFO_W-1:0] su_head;

	logic op_sb;
	logic op_sh;
	logic op_sw;
	logic op_sd;
	logic [XLEN-1:0] su_imm;
	logic [REG_AW-1:0] su_rs1;
	logic [REG_AW-1:0] su_rs2;

	issue_fifo #(
		.DW (SU_INFO_W),
		.DP (SU_DEPTH)
	) i_su_fifo (
		.CLK       (CLK),
		.rst       (rst),
		.push      (su_push),
		.info_push (su_issue_info),
		.pop       (su_pop),
		.info_pop  (su_head),
		.full      (su_full),
		.empty     (su_empty)
	);

	assign {op_sb, op_sh, op_sw, op_sd, su_imm, su_rs1, su_rs2} = su_head;

	// Both sources must be written back
	assign su_execute_valid = ~su_empty & reg_ready[su_rs1] & reg_ready[su_rs2];

	// Address from rs1, data straight from rs2
	assign su_execute_info = {
		op_sb, op_sh, op_sw, op_sd,
		reg_data[su_rs1*XLEN +: XLEN] + su_imm,
		reg_data[su_rs2*XLEN +: XLEN]
	};

	assign su_pop = su_execute_valid & su_execute_ready;
	// Room now or the head leaves this cycle
	assign su_issue_ready = (~su_full | su_pop) & ~su_block;
	assign su_push = su_issue_valid & su_issue_ready;

	// Single fence slot
	logic fence_push;
	logic fence_pop;
	logic fence_full;
	logic fence_empty;
	logic [FENCE_INFO_W-1:0] fence_head;

	issue_fifo #(
		.DW (FENCE_INFO_W),
		.DP (1)
	) i_fence_fifo (
		.CLK       (CLK),
		.rst       (rst),
		.push      (fence_push),
		.info_push (fence_issue_info),
		.pop       (fence_pop),
		.info_pop  (fence_head),
		.full      (fence_full),
		.empty     (fence_empty)
	);

	fence_ctrl i_fence_ctrl (
		.fence_info     (fence_head),
		.held           (~fence_empty),
		.loads_pending  (|lu_occupied),
		.stores_pending (~su_empty),
		.lu_block       (lu_block),
		.su_block       (su_block),
		.execute_valid  (fence_execute_valid),
		.execute_info   (fence_execute_info)
	);

	assign fence_pop = fence_execute_valid & fence_execute_ready;
	assign fence_issue_ready = ~fence_full | fence_pop;
	assign fence_push = fence_issue_valid & fence_issue_ready;

endmodule

//--- sim/tb_lsu_issue.sv
// Load/store issue stage testbench
module tb_lsu_issue;

	timeunit 1ns;
	timeprecision 1ps;

	import lsu_pkg::*;

	logic CLK;
	logic rst;
	logic lu_issue_valid;
	logic lu_issue_ready;
	logic lu_execute_valid;
	logic lu_execute_ready;
	logic su_issue_valid;
	logic su_issue_ready;
	logic su_execute_valid;
	logic su_execute_ready;
	logic fence_issue_valid;
	logic fence_issue_ready;
	logic fence_execute_valid;
	logic fence_execute_ready;
	logic [LU_INFO_W-1:0] lu_issue_info;
	logic [LU_EXEC_W-1:0] lu_execute_info;
	logic [SU_INFO_W-1:0] su_issue_info;
	logic [SU_EXEC_W-1:0] su_execute_info;
	logic [FENCE_INFO_W-1:0] fence_issue_info;
	logic [FENCE_EXEC_W-1:0] fence_execute_info;
	logic [REG_NUM-1:0] reg_ready;
	logic [REG_NUM*XLEN-1:0] reg_data;

	// Scoreboard of dispatched work
	logic [LU_INFO_W-1:0] slot_word [LU_DEPTH];
	logic [LU_DEPTH-1:0] slot_used;
	logic [SU_INFO_W-1:0] store_q [$];
	logic fence_held;
	logic [FENCE_INFO_W-1:0] fence_word;
	logic lu_ok;
	logic su_ok;
	logic f_ok;
	int seed;
	int errors;
	int timeouts;
	int n_load;
	int n_store;
	int n_fence;

	lsu_issue i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [XLEN-1:0] reg_val(input logic [4:0] r);
		return reg_data[r*XLEN +: XLEN];
	endfunction

	// lb lh lw ld lbu lhu lwu, imm, rd, rs1
	function automatic logic [LU_INFO_W-1:0] make_load(input int op, input logic [4:0] rs1);
		logic [XLEN-1:0] imm;
		logic [4:0] rd;
		imm = {$random(seed), $random(seed)};
		rd = 5'($random(seed));
		return {7'b1000000 >> op, imm, rd, rs1};
	endfunction

	// sb sh sw sd, imm, rs1, rs2
	function automatic logic [SU_INFO_W-1:0] make_store(input int op, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [XLEN-1:0] imm;
		imm = {$random(seed), $random(seed)};
		return {4'b1000 >> op, imm, rs1, rs2};
	endfunction

	// Sets sit in the low byte of the immediate
	function automatic logic [FENCE_INFO_W-1:0] make_fence(input logic fi, input logic [3:0] pred,
		input logic [3:0] succ);
		return {fi, ~fi, 56'($random(seed)), pred, succ};
	endfunction

	// Signed and unsigned forms share one width flag
	function automatic logic [LU_EXEC_W-1:0] load_expect(input logic [LU_INFO_W-1:0] w);
		return {w[80] | w[76], w[79] | w[75], w[78] | w[74], w[77], w[9:5],
			reg_val(w[4:0]) + w[73:10], w[76] | w[75] | w[74]};
	endfunction

	function automatic logic [SU_EXEC_W-1:0] store_expect(input logic [SU_INFO_W-1:0] w);
		return {w[77:74], reg_val(w[9:5]) + w[73:10], reg_val(w[4:0])};
	endfunction

	function automatic logic accepting(input int path);
		return (path == 0) ? lu_issue_ready : (path == 1) ? su_issue_ready : fence_issue_ready;
	endfunction

	// Path 0 load, 1 store, 2 fence
	task automatic dispatch(input int path, input logic [127:0] w);
		int t;
		@(posedge CLK);
		if (path == 0) begin
			lu_issue_valid <= 1'b1;
			lu_issue_info <= w[LU_INFO_W-1:0];
		end else if (path == 1) begin
			su_issue_valid <= 1'b1;
			su_issue_info <= w[SU_INFO_W-1:0];
		end else begin
			fence_issue_valid <= 1'b1;
			fence_issue_info <= w[FENCE_INFO_W-1:0];
		end
		t = 0;
		@(negedge CLK);
		while (!accepting(path) && t < 200) begin
			@(negedge CLK);
			t++;
		end
		if (t >= 200) begin
			timeouts++;
			$display("Timeout: dispatch on path %0d was never accepted", path);
		end
		@(posedge CLK);
		lu_issue_valid <= 1'b0;
		su_issue_valid <= 1'b0;
		fence_issue_valid <= 1'b0;
	endtask

	task automatic set_ready(input int r, input logic v);
		@(posedge CLK);
		reg_ready[r] <= v;
	endtask

	// Until loads, stores and fence have all left
	task automatic drain();
		int t;
		t = 0;
		@(posedge CLK);
		while ((slot_used != '0 || store_q.size() != 0 || fence_held) && t < 200) begin
			@(posedge CLK);
			t++;
		end
		if (t >= 200) begin
			timeouts++;
			$display("Timeout: instructions still waiting in the issue stage");
		end
	endtask

	// Expected behavior, stepped at the falling edge
	always @(negedge CLK) begin
		int pick;
		logic lu_v;
		logic su_v;
		logic f_v;
		logic lu_fire;
		logic su_fire;
		logic f_fire;
		logic lu_rdy;
		logic su_rdy;
		logic f_rdy;
		logic fi;
		logic ord_l;
		logic ord_s;
		logic hold_l;
		logic hold_s;
		if (rst) begin
			slot_used = '0;
			store_q.delete();
			fence_held = 1'b0;
			lu_ok = 1'b1;
			su_ok = 1'b1;
			f_ok = 1'b1;
		end else begin
			// Lowest held load with its base ready
			pick = 0;
			lu_v = 1'b0;
			for (int i = LU_DEPTH - 1; i >= 0; i--) begin
				if (slot_used[i] && reg_ready[slot_word[i][4:0]]) begin
					pick = i;
					lu_v = 1'b1;
				end
			end
			su_v = store_q.size() != 0 && reg_ready[store_q[0][9:5]]
				&& reg_ready[store_q[0][4:0]];
			// Load class 1010, store class 0101
			fi = fence_word[65];
			hold_l = fi | (fence_word[64] & |(fence_word[3:0] & 4'b1010));
			hold_s = fi | (fence_word[64] & |(fence_word[3:0] & 4'b0101));
			ord_l = fi | (fence_word[64] & |(fence_word[7:4] & 4'b1010));
			ord_s = fi | (fence_word[64] & |(fence_word[7:4] & 4'b0101));
			f_v = fence_held & ~(ord_l & |slot_used) & ~(ord_s & (store_q.size() != 0));
			lu_fire = lu_v & lu_execute_ready;
			su_fire = su_v & su_execute_ready;
			f_fire = f_v & fence_execute_ready;
			lu_rdy = (~&slot_used | lu_fire) & ~(fence_held & hold_l);
			su_rdy = (store_q.size() < SU_DEPTH || su_fire) && !(fence_held && hold_s);
			f_rdy = ~fence_held | f_fire;
			lu_ok = lu_execute_valid === lu_v && lu_issue_ready === lu_rdy
				&& (!lu_v || lu_execute_info === load_expect(slot_word[pick]));
			su_ok = su_execute_valid === su_v && su_issue_ready === su_rdy
				&& (!su_v || su_execute_info === store_expect(store_q[0]));
			f_ok = fence_execute_valid === f_v && fence_issue_ready === f_rdy
				&& (!f_v || fence_execute_info === {fi, fence_word[7:4], fence_word[3:0]});
			// Leaving entries free their place before new ones arrive
			if (lu_fire) begin
				slot_used[pick] = 1'b0;
				n_load++;
			end
			if (lu_issue_valid && lu_rdy) begin
				for (int i = LU_DEPTH - 1; i >= 0; i--) begin
					if (!slot_used[i]) begin
						pick = i;
					end
				end
				slot_word[pick] = lu_issue_info;
				slot_used[pick] = 1'b1;
			end
			if (su_fire) begin
				void'(store_q.pop_front());
				n_store++;
			end
			if (su_issue_valid && su_rdy) begin
				store_q.push_back(su_issue_info);
			end
			if (f_fire) begin
				fence_held = 1'b0;
				n_fence++;
			end
			if (fence_issue_valid && f_rdy) begin
				fence_held = 1'b1;
				fence_word = fence_issue_info;
			end
		end
	end

	a_reset: assert property (@(posedge CLK) $past(rst) && !rst |-> !lu_execute_valid
		&& !su_execute_valid && !fence_execute_valid && lu_issue_ready && su_issue_ready
		&& fence_issue_ready) else begin
		errors++;
		$display("ERR %0t: outputs after reset are not idle", $time);
	end
	a_load: assert property (@(posedge CLK) disable iff (rst) lu_ok) else begin
		errors++;
		$display("ERR %0t: load path valid, ready or execute word wrong", $time);
	end
	a_store: assert property (@(posedge CLK) disable iff (rst) su_ok) else begin
		errors++;
		$display("ERR %0t: store path valid, ready or execute word wrong", $time);
	end
	a_fence: assert property (@(posedge CLK) disable iff (rst) f_ok) else begin
		errors++;
		$display("ERR %0t: fence path valid, ready or execute word wrong", $time);
	end

	initial begin
		seed = 37159;
		errors = 0;
		timeouts = 0;
		n_load = 0;
		n_store = 0;
		n_fence = 0;
		rst = 1'b1;
		lu_issue_valid = 1'b0;
		su_issue_valid = 1'b0;
		fence_issue_valid = 1'b0;
		lu_issue_info = '0;
		su_issue_info = '0;
		fence_issue_info = '0;
		lu_execute_ready = 1'b1;
		su_execute_ready = 1'b1;
		fence_execute_ready = 1'b1;
		reg_ready = '1;
		for (int r = 0; r < REG_NUM; r++) begin
			reg_data[r*XLEN +: XLEN] = {$random(seed), $random(seed)};
		end
		repeat (10) @(posedge CLK);
		rst <= 1'b0;
		// Mixed traffic with every register ready
		for (int i = 0; i < 8; i++) begin
			dispatch(0, make_load(i % 7, 5'($random(seed))));
			dispatch(1, make_store(i % 4, 5'($random(seed)), 5'($random(seed))));
		end
		drain();
		// Younger load overtakes one with an unready base
		set_ready(5, 1'b0);
		dispatch(0, make_load(3, 5));
		dispatch(0, make_load(5, 6));
		repeat (4) @(posedge CLK);
		set_ready(5, 1'b1);
		drain();
		// Second store queues behind a head waiting on rs2
		set_ready(7, 1'b0);
		dispatch(1, make_store(0, 2, 7));
		dispatch(1, make_store(3, 4, 8));
		repeat (4) @(posedge CLK);
		set_ready(7, 1'b1);
		drain();
		// Stalled execute side fills both buffers
		@(posedge CLK);
		lu_execute_ready <= 1'b0;
		su_execute_ready <= 1'b0;
		for (int i = 0; i < 4; i++) begin
			dispatch(0, make_load(i, 5'(i + 10)));
			dispatch(1, make_store(i, 5'(i + 1), 5'(i + 20)));
		end
		// Fifth load and store enter as the oldest entry leaves
		fork
			dispatch(0, make_load(4, 5'd15));
			begin
				repeat (3) @(posedge CLK);
				lu_execute_ready <= 1'b1;
			end
		join
		fork
			dispatch(1, make_store(0, 5'd5, 5'd25));
			begin
				repeat (3) @(posedge CLK);
				su_execute_ready <= 1'b1;
			end
		join
		drain();
		// Fence after a held load, successors cover both classes
		set_ready(9, 1'b0);
		dispatch(0, make_load(2, 9));
		dispatch(2, make_fence(1'b0, 4'b1010, 4'b1111));
		repeat (4) @(posedge CLK);
		set_ready(9, 1'b1);
		dispatch(1, make_store(1, 3, 4));
		drain();
		// fence.i behind a held store
		set_ready(12, 1'b0);
		dispatch(1, make_store(2, 12, 13));
		dispatch(2, make_fence(1'b1, 4'b0000, 4'b0000));
		repeat (4) @(posedge CLK);
		set_ready(12, 1'b1);
		// A second fence enters as fence.i leaves
		dispatch(2, make_fence(1'b0, 4'b0101, 4'b1010));
		dispatch(0, make_load(6, 14));
		drain();
		$display("Issued %0d loads, %0d stores, %0d fences; %0d errors, %0d timeouts",
			n_load, n_store, n_fence, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
src/lsu_pkg.sv
src/issue_fifo.sv
src/lu_slot.sv
src/lu_alloc.sv
src/lu_pick.sv
src/fence_ctrl.sv
src/lsu_issue.sv
sim/tb_lsu_issue.sv

//--- Makefile
TOOL     = verilator
TOP      = tb_lsu_issue
FILELIST = build.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG) || [ $$rc -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
